// File: rtl/id_mgmt_defs.svh
`ifndef ID_MGMT_DEFS_SVH
`define ID_MGMT_DEFS_SVH

// Size of the instruction ID pool (a power of two)
`define ID_MGMT_MAX_IDS 8

// Number of retire ports feeding the toggle memories
`define ID_MGMT_COMMIT_PORTS 2

// Width of the running completion total
`define ID_MGMT_TOTAL_W 32

`endif

// File: rtl/id_mgmt_pkg.sv
`include "id_mgmt_defs.svh"

package id_mgmt_pkg;

    // ID width follows the pool size
    localparam int ID_W = $clog2(`ID_MGMT_MAX_IDS);

    // Branch, store and system sources plus one per retire port
    localparam int MAX_COMPLETE_COUNT = 3 + `ID_MGMT_COMMIT_PORTS;
    localparam int COMPLETE_COUNT_W = $clog2(MAX_COMPLETE_COUNT + 1);

    typedef logic [ID_W-1:0] id_t;
    typedef logic [COMPLETE_COUNT_W-1:0] complete_count_t;
    typedef logic [`ID_MGMT_TOTAL_W-1:0] retire_total_t;

endpackage

// File: rtl/toggle_memory.sv
`timescale 1ns/1ps

`include "id_mgmt_defs.svh"

module toggle_memory
    import id_mgmt_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic toggle_i,
    input  id_t  toggle_id_i,

    input  id_t  read_id_i,
    output logic read_data_o
);

    // One state bit per ID
    logic [`ID_MGMT_MAX_IDS-1:0] toggle_bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            toggle_bits <= '0;
        end else if (toggle_i) begin
            toggle_bits[toggle_id_i] <= ~toggle_bits[toggle_id_i];
        end
    end

    // Asynchronous read of the addressed bit
    assign read_data_o = toggle_bits[read_id_i];

endmodule

// File: rtl/id_fifo.sv
`timescale 1ns/1ps

`include "id_mgmt_defs.svh"

module id_fifo
    import id_mgmt_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic flush_i,

    input  logic push_i,
    input  id_t  push_id_i,

    input  logic pop_i,
    output id_t  head_id_o,
    output logic valid_o
);

    localparam int DEPTH   = `ID_MGMT_MAX_IDS;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    // Storage, one slot per pool entry
    id_t storage [DEPTH];

    // Pointers wrap naturally since the depth is a power of two
    id_t write_ptr;
    id_t read_ptr;
    logic [COUNT_W-1:0] count;

    ////////////////////////////////////////
    // Pointer and occupancy control

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (push_i)
                write_ptr <= write_ptr + id_t'(1);
            if (pop_i)
                read_ptr <= read_ptr + id_t'(1);
            if (push_i && !pop_i)
                count <= count + COUNT_W'(1);
            else if (pop_i && !push_i)
                count <= count - COUNT_W'(1);
        end
    end

    ////////////////////////////////////////
    // Data path

    always_ff @(posedge clk) begin
        if (push_i)
            storage[write_ptr] <= push_id_i;
    end

    assign head_id_o = storage[read_ptr];
    assign valid_o   = (count != '0);

endmodule

// File: rtl/id_management.sv
`timescale 1ns/1ps

`include "id_mgmt_defs.svh"

module id_management
    import id_mgmt_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic fetch_flush_i,

    // PC stage ID issue
    output id_t  pc_id_o,
    output logic pc_id_available_o,
    input  logic pc_id_assigned_i,
    input  logic fetch_complete_i,

    // Decode stage
    input  logic decode_advance_i,
    output id_t  decode_id_o,
    output logic decode_id_valid_o,

    // Issue stage
    input  logic issue_stage_valid_i,
    input  logic issued_i,
    input  logic issue_uses_rd_i,
    input  id_t  issue_id_i,

    // Operand lookups from the register-to-ID table
    input  id_t  rs1_id_i,
    input  id_t  rs2_id_i,
    output logic rs1_inuse_o,
    output logic rs2_inuse_o,

    // Completion sources
    input  logic store_complete_i,
    input  id_t  store_id_i,
    input  logic branch_complete_i,
    input  id_t  branch_id_i,
    input  logic sys_complete_i,
    input  logic exception_rd_complete_i,
    input  id_t  sys_id_i,

    // Retire ports
    input  id_t  retire_id_i [`ID_MGMT_COMMIT_PORTS],
    input  logic retired_i [`ID_MGMT_COMMIT_PORTS],

    output complete_count_t retire_inc_o
);

    localparam int COMMIT_PORTS = `ID_MGMT_COMMIT_PORTS;

    id_t fetch_id;
    id_t pc_id_next;
    id_t flush_restore_id;

    // Toggle memory read results
    logic decoded_status;
    logic decoded_issued_status;
    logic issued_status;
    logic issued_rs1_status;
    logic issued_rs2_status;
    logic branch_status;
    logic store_status;
    logic sys_status;
    logic exception_rs1_status;
    logic exception_rs2_status;
    logic [COMMIT_PORTS-1:0] retired_status;
    logic [COMMIT_PORTS-1:0] retired_rs1_status;
    logic [COMMIT_PORTS-1:0] retired_rs2_status;

    logic retired_xor;
    logic retired_rs1_xor;
    logic retired_rs2_xor;
    logic id_free;
    complete_count_t complete_count;

    ////////////////////////////////////////
    // PC and fetch ID counters

    assign pc_id_next = pc_id_o + id_t'(pc_id_assigned_i);

    // Flush resumes at the oldest unissued ID so no pooled ID is lost
    assign flush_restore_id = decode_id_valid_o ? decode_id_o : pc_id_o;

    always_ff @(posedge clk) begin
        if (rst)
            pc_id_o <= '0;
        else if (fetch_flush_i)
            pc_id_o <= flush_restore_id;
        else
            pc_id_o <= pc_id_next;
    end

    always_ff @(posedge clk) begin
        if (rst)
            fetch_id <= '0;
        else if (fetch_flush_i)
            fetch_id <= flush_restore_id;
        else
            fetch_id <= fetch_id + id_t'(fetch_complete_i);
    end

    ////////////////////////////////////////
    // Fetched IDs waiting for decode

    id_fifo fetch_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (fetch_flush_i),
        .push_i    (fetch_complete_i),
        .push_id_i (fetch_id),
        .pop_i     (decode_advance_i),
        .head_id_o (decode_id_o),
        .valid_o   (decode_id_valid_o)
    );

    ////////////////////////////////////////
    // Toggle memories
    // Each source owns one memory and the XOR of all gives the stage status

    // Decoded vs issued-or-flushed pair
    toggle_memory decode_mem (
        .clk(clk), .rst(rst),
        .toggle_i(decode_advance_i & ~fetch_flush_i), .toggle_id_i(decode_id_o),
        .read_id_i(pc_id_next), .read_data_o(decoded_status)
    );
    toggle_memory decoded_issued_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issued_i | (fetch_flush_i & issue_stage_valid_i)),
        .toggle_id_i(issue_id_i),
        .read_id_i(pc_id_next), .read_data_o(decoded_issued_status)
    );

    // Issue side of the in-flight tracking
    toggle_memory issued_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issued_i), .toggle_id_i(issue_id_i),
        .read_id_i(pc_id_next), .read_data_o(issued_status)
    );
    toggle_memory issued_rs1_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issued_i & issue_uses_rd_i), .toggle_id_i(issue_id_i),
        .read_id_i(rs1_id_i), .read_data_o(issued_rs1_status)
    );
    toggle_memory issued_rs2_mem (
        .clk(clk), .rst(rst),
        .toggle_i(issued_i & issue_uses_rd_i), .toggle_id_i(issue_id_i),
        .read_id_i(rs2_id_i), .read_data_o(issued_rs2_status)
    );

    // Completion side
    toggle_memory branch_mem (
        .clk(clk), .rst(rst),
        .toggle_i(branch_complete_i), .toggle_id_i(branch_id_i),
        .read_id_i(pc_id_next), .read_data_o(branch_status)
    );
    toggle_memory store_mem (
        .clk(clk), .rst(rst),
        .toggle_i(store_complete_i), .toggle_id_i(store_id_i),
        .read_id_i(pc_id_next), .read_data_o(store_status)
    );
    toggle_memory sys_mem (
        .clk(clk), .rst(rst),
        .toggle_i(sys_complete_i), .toggle_id_i(sys_id_i),
        .read_id_i(pc_id_next), .read_data_o(sys_status)
    );
    toggle_memory exception_rs1_mem (
        .clk(clk), .rst(rst),
        .toggle_i(exception_rd_complete_i), .toggle_id_i(sys_id_i),
        .read_id_i(rs1_id_i), .read_data_o(exception_rs1_status)
    );
    toggle_memory exception_rs2_mem (
        .clk(clk), .rst(rst),
        .toggle_i(exception_rd_complete_i), .toggle_id_i(sys_id_i),
        .read_id_i(rs2_id_i), .read_data_o(exception_rs2_status)
    );

    // Three memories per retire port
    for (genvar p = 0; p < COMMIT_PORTS; p++) begin : g_commit
        toggle_memory retired_mem (
            .clk(clk), .rst(rst),
            .toggle_i(retired_i[p]), .toggle_id_i(retire_id_i[p]),
            .read_id_i(pc_id_next), .read_data_o(retired_status[p])
        );
        toggle_memory retired_rs1_mem (
            .clk(clk), .rst(rst),
            .toggle_i(retired_i[p]), .toggle_id_i(retire_id_i[p]),
            .read_id_i(rs1_id_i), .read_data_o(retired_rs1_status[p])
        );
        toggle_memory retired_rs2_mem (
            .clk(clk), .rst(rst),
            .toggle_i(retired_i[p]), .toggle_id_i(retire_id_i[p]),
            .read_id_i(rs2_id_i), .read_data_o(retired_rs2_status[p])
        );
    end

    ////////////////////////////////////////
    // Status and counts

    assign retired_xor     = ^retired_status;
    assign retired_rs1_xor = ^retired_rs1_status;
    assign retired_rs2_xor = ^retired_rs2_status;

    // Free once it has left decode/issue and every issue is matched by a completion
    assign id_free = ~(decoded_status ^ decoded_issued_status)
                   & ~(issued_status ^ branch_status ^ store_status
                       ^ sys_status ^ retired_xor);

    always_ff @(posedge clk) begin
        if (rst)
            pc_id_available_o <= 1'b1;
        else
            pc_id_available_o <= id_free;
    end

    // Only register-writing IDs live in the table, so branch and store are skipped
    assign rs1_inuse_o = issued_rs1_status ^ exception_rs1_status ^ retired_rs1_xor;
    assign rs2_inuse_o = issued_rs2_status ^ exception_rs2_status ^ retired_rs2_xor;

    always_comb begin
        complete_count = complete_count_t'(branch_complete_i)
                       + complete_count_t'(store_complete_i)
                       + complete_count_t'(sys_complete_i);
        for (int p = 0; p < COMMIT_PORTS; p++)
            complete_count = complete_count + complete_count_t'(retired_i[p]);
    end

    always_ff @(posedge clk) begin
        if (rst)
            retire_inc_o <= '0;
        else
            retire_inc_o <= complete_count;
    end

endmodule

// File: rtl/retire_counter.sv
`timescale 1ns/1ps

module retire_counter
    import id_mgmt_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    // Completions seen in the previous cycle
    input  complete_count_t retire_inc_i,

    // Running total for the performance counter
    output retire_total_t   retire_total_o
);

    ////////////////////////////////////////
    // Accumulator that wraps at its width

    always_ff @(posedge clk) begin
        if (rst)
            retire_total_o <= '0;
        else
            retire_total_o <= retire_total_o + retire_total_t'(retire_inc_i);
    end

endmodule

// File: rtl/id_tracking_unit.sv
`timescale 1ns/1ps

`include "id_mgmt_defs.svh"

module id_tracking_unit
    import id_mgmt_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic fetch_flush_i,

    output id_t  pc_id_o,
    output logic pc_id_available_o,
    input  logic pc_id_assigned_i,
    input  logic fetch_complete_i,

    input  logic decode_advance_i,
    output id_t  decode_id_o,
    output logic decode_id_valid_o,

    input  logic issue_stage_valid_i,
    input  logic issued_i,
    input  logic issue_uses_rd_i,
    input  id_t  issue_id_i,

    input  id_t  rs1_id_i,
    input  id_t  rs2_id_i,
    output logic rs1_inuse_o,
    output logic rs2_inuse_o,

    input  logic store_complete_i,
    input  id_t  store_id_i,
    input  logic branch_complete_i,
    input  id_t  branch_id_i,
    input  logic sys_complete_i,
    input  logic exception_rd_complete_i,
    input  id_t  sys_id_i,

    input  id_t  retire_id_i [`ID_MGMT_COMMIT_PORTS],
    input  logic retired_i [`ID_MGMT_COMMIT_PORTS],

    output retire_total_t retire_total_o
);

    // Per-cycle completions into the performance counter
    complete_count_t retire_inc;

    id_management id_management_inst (
        .clk                     (clk),
        .rst                     (rst),
        .fetch_flush_i           (fetch_flush_i),
        .pc_id_o                 (pc_id_o),
        .pc_id_available_o       (pc_id_available_o),
        .pc_id_assigned_i        (pc_id_assigned_i),
        .fetch_complete_i        (fetch_complete_i),
        .decode_advance_i        (decode_advance_i),
        .decode_id_o             (decode_id_o),
        .decode_id_valid_o       (decode_id_valid_o),
        .issue_stage_valid_i     (issue_stage_valid_i),
        .issued_i                (issued_i),
        .issue_uses_rd_i         (issue_uses_rd_i),
        .issue_id_i              (issue_id_i),
        .rs1_id_i                (rs1_id_i),
        .rs2_id_i                (rs2_id_i),
        .rs1_inuse_o             (rs1_inuse_o),
        .rs2_inuse_o             (rs2_inuse_o),
        .store_complete_i        (store_complete_i),
        .store_id_i              (store_id_i),
        .branch_complete_i       (branch_complete_i),
        .branch_id_i             (branch_id_i),
        .sys_complete_i          (sys_complete_i),
        .exception_rd_complete_i (exception_rd_complete_i),
        .sys_id_i                (sys_id_i),
        .retire_id_i             (retire_id_i),
        .retired_i               (retired_i),
        .retire_inc_o            (retire_inc)
    );

    retire_counter retire_counter_inst (
        .clk            (clk),
        .rst            (rst),
        .retire_inc_i   (retire_inc),
        .retire_total_o (retire_total_o)
    );

endmodule

// File: tests/id_tracking_properties.sv
`timescale 1ns/1ps

`include "id_mgmt_defs.svh"

module id_tracking_properties #(
    parameter int COUNT_W = $clog2(`ID_MGMT_MAX_IDS + 1)
) (
    input logic               clk,
    input logic               rst,
    input logic               pc_id_assigned_i,
    input logic               pc_id_available_o,
    input logic               decode_advance_i,
    input logic               decode_id_valid_o,
    input logic [COUNT_W-1:0] fifo_count_i
);

    localparam logic [COUNT_W-1:0] MAX_COUNT = COUNT_W'(`ID_MGMT_MAX_IDS);

    // PC stage only takes an ID that is known to be free
    assign_when_available: assert property (
        @(posedge clk) disable iff (rst) pc_id_assigned_i |-> pc_id_available_o
    ) else $error("ID assigned while the next PC ID is not available");

    decode_needs_valid: assert property (
        @(posedge clk) disable iff (rst) decode_advance_i |-> decode_id_valid_o
    ) else $error("Decode advanced without a valid ID");

    // Queue is as deep as the pool
    fifo_within_pool: assert property (
        @(posedge clk) disable iff (rst) fifo_count_i <= MAX_COUNT
    ) else $error("Fetch queue holds more IDs than the pool size");

endmodule

bind id_management id_tracking_properties id_tracking_properties_inst (
    .clk               (clk),
    .rst               (rst),
    .pc_id_assigned_i  (pc_id_assigned_i),
    .pc_id_available_o (pc_id_available_o),
    .decode_advance_i  (decode_advance_i),
    .decode_id_valid_o (decode_id_valid_o),
    .fifo_count_i      (fetch_fifo_inst.count)
);

// File: tests/id_tracking_tb.sv
`timescale 1ns/1ps

`include "id_mgmt_defs.svh"

module id_tracking_tb
    import id_mgmt_pkg::*;
();

    localparam int MAX_IDS         = `ID_MGMT_MAX_IDS;
    localparam int CLK_PERIOD      = 4;
    localparam int NUM_STEPS       = 29;
    localparam int MAX_STEP_CYCLES = 16;
    localparam int WATCHDOG_NS     = NUM_STEPS * MAX_STEP_CYCLES * CLK_PERIOD + 200;

    typedef enum logic [3:0] {
        STEP_CHECK, STEP_FETCH, STEP_DECODE, STEP_ISSUE, STEP_RETIRE,
        STEP_EXCEPT, STEP_BRANCH, STEP_STORE, STEP_FLUSH
    } step_kind_e;

    // A count of zero means LFSR burst for fetch, or everything pending otherwise
    typedef struct packed {
        step_kind_e kind;
        logic [3:0] count;
        logic       uses_rd;
    } step_t;

    localparam step_t STEPS [NUM_STEPS] = '{
        '{STEP_CHECK, 4'd0, 1'b0},  '{STEP_FETCH, 4'd0, 1'b0},  '{STEP_DECODE, 4'd0, 1'b0},
        '{STEP_ISSUE, 4'd0, 1'b1},  '{STEP_RETIRE, 4'd0, 1'b0}, '{STEP_FETCH, 4'd3, 1'b0},
        '{STEP_DECODE, 4'd0, 1'b0}, '{STEP_ISSUE, 4'd1, 1'b0},  '{STEP_ISSUE, 4'd2, 1'b1},
        '{STEP_BRANCH, 4'd1, 1'b0}, '{STEP_EXCEPT, 4'd1, 1'b0}, '{STEP_RETIRE, 4'd1, 1'b0},
        '{STEP_FETCH, 4'd3, 1'b0},  '{STEP_DECODE, 4'd1, 1'b0}, '{STEP_FLUSH, 4'd0, 1'b0},
        '{STEP_FLUSH, 4'd0, 1'b0},  '{STEP_ISSUE, 4'd0, 1'b0},  '{STEP_STORE, 4'd0, 1'b0},
        '{STEP_FETCH, 4'd0, 1'b0},  '{STEP_DECODE, 4'd0, 1'b0}, '{STEP_ISSUE, 4'd0, 1'b1},
        '{STEP_RETIRE, 4'd0, 1'b0}, '{STEP_FETCH, 4'd8, 1'b0},  '{STEP_DECODE, 4'd0, 1'b0},
        '{STEP_ISSUE, 4'd0, 1'b1},  '{STEP_RETIRE, 4'd1, 1'b0}, '{STEP_EXCEPT, 4'd2, 1'b0},
        '{STEP_RETIRE, 4'd0, 1'b0}, '{STEP_CHECK, 4'd0, 1'b0}
    };

    logic clk = 1'b0;
    logic rst;
    logic fetch_flush_i;
    id_t  pc_id_o;
    logic pc_id_available_o;
    logic pc_id_assigned_i;
    logic fetch_complete_i;
    logic decode_advance_i;
    id_t  decode_id_o;
    logic decode_id_valid_o;
    logic issue_stage_valid_i;
    logic issued_i;
    logic issue_uses_rd_i;
    id_t  issue_id_i;
    id_t  rs1_id_i;
    id_t  rs2_id_i;
    logic rs1_inuse_o;
    logic rs2_inuse_o;
    logic store_complete_i;
    id_t  store_id_i;
    logic branch_complete_i;
    id_t  branch_id_i;
    logic sys_complete_i;
    logic exception_rd_complete_i;
    id_t  sys_id_i;
    id_t  retire_id_i [`ID_MGMT_COMMIT_PORTS];
    logic retired_i [`ID_MGMT_COMMIT_PORTS];
    retire_total_t retire_total_o;

    // Reference model state
    id_t pc_m;
    id_t fetch_m;
    id_t fetch_q [$];
    id_t pend_q [$];
    id_t fly_q [$];
    logic dec_busy_m [MAX_IDS];
    logic fly_busy_m [MAX_IDS];
    logic inuse_m [MAX_IDS];
    retire_total_t total_m;

    logic [15:0] lfsr_state = 16'd35789;
    int error_count;
    int steps_ok;
    int steps_bad;

    always #(CLK_PERIOD / 2) clk = ~clk;

    id_tracking_unit id_tracking_unit_inst (.*);

    ////////////////////////////////////////
    // Helpers

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_id(input id_t actual, input id_t expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual,
                     expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual,
                     expected);
        end
    endtask

    task automatic check_total(input retire_total_t actual, input retire_total_t expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual,
                     expected);
        end
    endtask

    task automatic clear_strobes();
        fetch_flush_i           <= 1'b0;
        pc_id_assigned_i        <= 1'b0;
        fetch_complete_i        <= 1'b0;
        decode_advance_i        <= 1'b0;
        issue_stage_valid_i     <= 1'b0;
        issued_i                <= 1'b0;
        issue_uses_rd_i         <= 1'b0;
        store_complete_i        <= 1'b0;
        branch_complete_i       <= 1'b0;
        sys_complete_i          <= 1'b0;
        exception_rd_complete_i <= 1'b0;
        for (int p = 0; p < `ID_MGMT_COMMIT_PORTS; p++)
            retired_i[p] <= 1'b0;
    endtask

    // Look up the given ID and its neighbour on the operand ports
    task automatic aim_operands(input id_t id);
        rs1_id_i <= id;
        rs2_id_i <= id + id_t'(1);
    endtask

    task automatic check_state();
        check_id(pc_id_o, pc_m, "pc_id");
        check_flag(pc_id_available_o, !(dec_busy_m[pc_m] || fly_busy_m[pc_m]), "pc_id_available");
        check_flag(decode_id_valid_o, fetch_q.size() != 0, "decode_id_valid");
        if (fetch_q.size() != 0)
            check_id(decode_id_o, fetch_q[0], "decode_id");
        check_total(retire_total_o, total_m, "retire_total");
    endtask

    ////////////////////////////////////////
    // Step execution

    task automatic run_step(input step_t s);
        int n;
        int bits;
        logic port_sel;
        id_t id;
        n = int'(s.count);
        case (s.kind)
            STEP_FETCH: begin
                if (n == 0) begin
                    take_bits(2, bits);
                    n = bits + 1;
                end
                if (n > MAX_IDS - fetch_q.size() - pend_q.size() - fly_q.size())
                    n = MAX_IDS - fetch_q.size() - pend_q.size() - fly_q.size();
                repeat (n) begin
                    @(posedge clk);
                    pc_id_assigned_i <= 1'b1;
                    fetch_complete_i <= 1'b1;
                    aim_operands(pc_m);
                    fetch_q.push_back(fetch_m);
                    pc_m = pc_m + id_t'(1);
                    fetch_m = fetch_m + id_t'(1);
                end
            end
            STEP_DECODE: begin
                if (n == 0)
                    n = fetch_q.size();
                repeat (n) begin
                    @(posedge clk);
                    decode_advance_i <= 1'b1;
                    @(negedge clk);
                    id = fetch_q.pop_front();
                    check_flag(decode_id_valid_o, 1'b1, "decode_id_valid before pop");
                    check_id(decode_id_o, id, "decode_id in fetch order");
                    pend_q.push_back(id);
                    dec_busy_m[id] = 1'b1;
                end
            end
            STEP_ISSUE: begin
                if (n == 0)
                    n = pend_q.size();
                repeat (n) begin
                    @(posedge clk);
                    id = pend_q.pop_front();
                    issue_stage_valid_i <= 1'b1;
                    issued_i <= 1'b1;
                    issue_uses_rd_i <= s.uses_rd;
                    issue_id_i <= id;
                    aim_operands(id);
                    dec_busy_m[id] = 1'b0;
                    fly_busy_m[id] = 1'b1;
                    inuse_m[id] = s.uses_rd;
                    fly_q.push_back(id);
                end
            end
            STEP_RETIRE, STEP_EXCEPT, STEP_BRANCH, STEP_STORE: begin
                if (n == 0)
                    n = fly_q.size();
                repeat (n) begin
                    @(posedge clk);
                    id = fly_q.pop_front();
                    aim_operands(id);
                    fly_busy_m[id] = 1'b0;
                    total_m = total_m + retire_total_t'(1);
                    if (s.kind == STEP_RETIRE) begin
                        take_bits(1, bits);
                        port_sel = bits[0];
                        clear_strobes();
                        retired_i[port_sel] <= 1'b1;
                        retire_id_i[port_sel] <= id;
                        inuse_m[id] = 1'b0;
                    end else if (s.kind == STEP_EXCEPT) begin
                        sys_complete_i <= 1'b1;
                        exception_rd_complete_i <= 1'b1;
                        sys_id_i <= id;
                        inuse_m[id] = 1'b0;
                    end else if (s.kind == STEP_BRANCH) begin
                        branch_complete_i <= 1'b1;
                        branch_id_i <= id;
                    end else begin
                        store_complete_i <= 1'b1;
                        store_id_i <= id;
                    end
                end
            end
            STEP_FLUSH: begin
                @(posedge clk);
                fetch_flush_i <= 1'b1;
                if (fetch_q.size() != 0)
                    pc_m = fetch_q[0];
                fetch_m = pc_m;
                fetch_q.delete();
            end
            default: begin
            end
        endcase
        // Last action lands here, operand status is combinational
        @(posedge clk);
        clear_strobes();
        @(negedge clk);
        check_flag(rs1_inuse_o, inuse_m[rs1_id_i], "rs1_inuse");
        check_flag(rs2_inuse_o, inuse_m[rs2_id_i], "rs2_inuse");
        // Registered availability and the total settle one edge later
        @(posedge clk);
        @(negedge clk);
        check_state();
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        int errors_before;
        step_kind_e kind_v;
        rst <= 1'b1;
        clear_strobes();
        issue_id_i <= '0;
        store_id_i <= '0;
        branch_id_i <= '0;
        sys_id_i <= '0;
        rs1_id_i <= '0;
        rs2_id_i <= '0;
        for (int p = 0; p < `ID_MGMT_COMMIT_PORTS; p++)
            retire_id_i[p] <= '0;
        for (int i = 0; i < MAX_IDS; i++) begin
            dec_busy_m[i] = 1'b0;
            fly_busy_m[i] = 1'b0;
            inuse_m[i] = 1'b0;
        end
        pc_m = '0;
        fetch_m = '0;
        total_m = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_STEPS; i++) begin
            errors_before = error_count;
            kind_v = STEPS[i].kind;
            run_step(STEPS[i]);
            if (error_count == errors_before) begin
                steps_ok++;
                $display("step %0d %s: ok", i, kind_v.name());
            end else begin
                steps_bad++;
                $display("step %0d %s: %0d mismatches", i, kind_v.name(),
                         error_count - errors_before);
            end
        end

        $display("%0d steps ok, %0d steps with errors", steps_ok, steps_bad);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
rtl/id_mgmt_pkg.sv
rtl/toggle_memory.sv
rtl/id_fifo.sv
rtl/id_management.sv
rtl/retire_counter.sv
rtl/id_tracking_unit.sv
tests/id_tracking_properties.sv
tests/id_tracking_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= id_tracking_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_MSG ?= Result: PASSED

.PHONY: sim clean

# Build and run, the status comes from the search for the pass line
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
